/* vlog.f */
+incdir+verification
hdl/rv_isa_pkg.sv
hdl/dmem_pkg.sv
hdl/ex_mem_if.sv
hdl/dmem_if.sv
hdl/mem_access.sv
hdl/load_format.sv
hdl/mem_wb_pipe.sv
hdl/rv_stage_mem.sv
verification/tb_stage_mem.sv

/* verification/stage_mem_stim.txt */
// ctl{stall,valid,rw,rd,wr,trap}_tcode_res_rd_f3_alu_rs2_pc4_tgt_rdata, then expected
// {ren,we,trap}_tcode_wstrb_wdata(if we)_load(if ren)_result
12_0_0_00_0_00001000_876543f1_00001004_00002000_80f17f82_2_0_1_f1f1f1f1_00000000_00001000
12_0_0_00_0_00001001_876543f1_00001004_00002000_80f17f82_2_0_2_f1f1f1f1_00000000_00001001
12_0_0_00_0_00001002_876543f1_00001004_00002000_80f17f82_2_0_4_f1f1f1f1_00000000_00001002
12_0_0_00_0_00001003_876543f1_00001004_00002000_80f17f82_2_0_8_f1f1f1f1_00000000_00001003
12_0_0_00_1_00001010_876543f1_00001004_00002000_80f17f82_2_0_3_43f143f1_00000000_00001010
12_0_0_00_1_00001012_876543f1_00001004_00002000_80f17f82_2_0_c_43f143f1_00000000_00001012
12_0_0_00_2_00001020_876543f1_00001004_00002000_80f17f82_2_0_f_876543f1_00000000_00001020
1c_0_0_05_0_00002000_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_ffffff82_00002000
1c_0_0_05_0_00002001_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_0000007f_00002001
1c_0_0_05_4_00002002_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_000000f1_00002002
1c_0_0_05_0_00002003_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_ffffff80_00002003
1c_0_0_05_1_00002004_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_00007f82_00002004
1c_0_0_05_1_00002006_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_ffff80f1_00002006
1c_0_0_05_5_0000200a_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_000080f1_0000200a
1c_0_0_05_2_0000200c_876543f1_00001004_00002000_80f17f82_4_0_0_00000000_80f17f82_0000200c
1c_0_0_06_1_00003001_876543f1_00001004_00002000_80f17f82_1_2_0_00000000_00000000_00003001
1c_0_0_07_2_00003005_876543f1_00001004_00002000_80f17f82_1_2_0_00000000_00000000_00003005
12_0_0_00_1_00003003_876543f1_00001004_00002000_80f17f82_1_2_0_00000000_00000000_00003003
1d_1_0_08_2_00003008_876543f1_00001004_00002000_80f17f82_1_1_0_00000000_00000000_00003008
18_0_2_0a_0_00004000_876543f1_00000104_00000200_80f17f82_0_0_0_00000000_00000000_00000104
18_0_3_0b_0_00004004_876543f1_00000108_00000204_80f17f82_0_0_0_00000000_00000000_00000204
38_0_0_0c_0_0000500c_876543f1_00000300_00000400_80f17f82_0_0_0_00000000_00000000_0000500c
08_0_0_0d_0_00006000_876543f1_00000500_00000600_80f17f82_0_0_0_00000000_00000000_00006000

/* verification/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Mismatches over the whole run, and per-test tallies
int err_count;
int pass_count;
int fail_count;

// Data words and byte addresses
task automatic check_word(input string name, input rv_isa_pkg::xlen_t got,
                          input rv_isa_pkg::xlen_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Byte-lane strobes
task automatic check_strb(input string name, input dmem_pkg::dmem_strb_t got,
                          input dmem_pkg::dmem_strb_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Single control bits
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Trap cause
task automatic check_trap(input string name, input rv_isa_pkg::trap_code_t got,
                          input rv_isa_pkg::trap_code_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Destination register index
task automatic check_rd(input string name, input rv_isa_pkg::reg_idx_t got,
                        input rv_isa_pkg::reg_idx_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Result source select
task automatic check_src(input string name, input rv_isa_pkg::res_src_t got,
                         input rv_isa_pkg::res_src_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// Load/store funct3
task automatic check_funct3(input string name, input rv_isa_pkg::funct3_t got,
                            input rv_isa_pkg::funct3_t exp);
  if (got !== exp) begin
    err_count++;
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

// One line per finished test
task automatic report_test(input string name, input int errs_before);
  if (err_count == errs_before) begin
    pass_count++;
    $display("%s passed", name);
  end else begin
    fail_count++;
    $display("%s failed", name);
  end
endtask

`endif

/* verification/tb_stage_mem.sv */
`timescale 1ns/1ns

module tb_stage_mem;

  localparam int MAX_VEC = 64;

  logic clk, rst_n, mem_wb_stall;
  logic valid_mem, reg_write_mem, mem_read_mem, mem_write_mem, trap_in;
  rv_isa_pkg::res_src_t res_src_mem, res_src_wb;
  rv_isa_pkg::reg_idx_t rd_mem, rd_wb;
  rv_isa_pkg::funct3_t funct3_mem, funct3_wb;
  rv_isa_pkg::xlen_t alu_result_mem, rs2_data_mem, pc_plus4_mem, jb_target_mem;
  rv_isa_pkg::trap_code_t trap_code_in, trap_code_wb;
  logic dmem_ren, dmem_we;
  dmem_pkg::dmem_addr_t dmem_raddr, dmem_waddr;
  dmem_pkg::dmem_word_t dmem_wdata, dmem_rdata;
  dmem_pkg::dmem_strb_t dmem_wstrb;
  rv_isa_pkg::xlen_t result_mem, load_data_mem;
  logic valid_wb, reg_write_wb, trap_wb;
  rv_isa_pkg::xlen_t alu_result_wb, load_data_wb, pc_plus4_wb, jb_target_wb;

  // One vector per word, field layout as in the stimulus file header
  logic [295:0] vecs [0:MAX_VEC-1];
  int num_vec;
  int cycle_count;
  int cycle_limit;

  // Expected MEM/WB register contents, loaded on unstalled cycles
  logic exp_valid, exp_rw, exp_trap, exp_ld_chk;
  rv_isa_pkg::trap_code_t exp_tc;
  rv_isa_pkg::xlen_t exp_alu, exp_pc4, exp_tgt, exp_ld;
  rv_isa_pkg::reg_idx_t exp_rd;
  rv_isa_pkg::res_src_t exp_src;
  rv_isa_pkg::funct3_t exp_f3;

  `include "tb_checks.svh"

  rv_stage_mem dut0 (.*);

  always #5 clk = ~clk;

  // Run limit, set once the vector count is known
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // MEM inputs and read data for one cycle
  task automatic drive_vector(input logic [295:0] v);
    mem_wb_stall = v[293];
    valid_mem = v[292];
    reg_write_mem = v[291];
    mem_read_mem = v[290];
    mem_write_mem = v[289];
    trap_in = v[288];
    trap_code_in = v[285:284];
    res_src_mem = rv_isa_pkg::res_src_t'(v[282:280]);
    rd_mem = v[276:272];
    funct3_mem = v[270:268];
    alu_result_mem = v[267:236];
    rs2_data_mem = v[235:204];
    pc_plus4_mem = v[203:172];
    jb_target_mem = v[171:140];
    dmem_rdata = v[139:108];
  endtask

  // Same-cycle outputs, before the rising edge
  task automatic check_comb(input logic [295:0] v);
    rv_isa_pkg::xlen_t word_addr;
    // Request address is the effective address with the byte offset dropped
    word_addr = {v[267:238], 2'b00};
    check_bit("dmem_ren", dmem_ren, v[106]);
    check_bit("dmem_we", dmem_we, v[105]);
    check_strb("dmem_wstrb", dmem_wstrb, v[99:96]);
    check_word("dmem_raddr", dmem_raddr, word_addr);
    check_word("dmem_waddr", dmem_waddr, word_addr);
    check_word("result_mem", result_mem, v[31:0]);
    // Store data only matters when the write goes out
    if (v[105])
      check_word("dmem_wdata", dmem_wdata, v[95:64]);
    if (v[106])
      check_word("load_data_mem", load_data_mem, v[63:32]);
  endtask

  // Next WB contents; trapped instructions lose their register write
  task automatic update_expect(input logic [295:0] v);
    exp_valid = v[292];
    exp_rw = v[291] & ~v[104];
    exp_trap = v[104];
    exp_tc = v[101:100];
    exp_rd = v[276:272];
    exp_src = rv_isa_pkg::res_src_t'(v[282:280]);
    exp_f3 = v[270:268];
    exp_alu = v[267:236];
    exp_pc4 = v[203:172];
    exp_tgt = v[171:140];
    exp_ld = v[63:32];
    exp_ld_chk = v[106];
  endtask

  // Registered outputs, after the rising edge
  task automatic check_wb();
    check_bit("valid_wb", valid_wb, exp_valid);
    // Payload is don't-care behind an invalid slot
    if (exp_valid) begin
      check_bit("reg_write_wb", reg_write_wb, exp_rw);
      check_bit("trap_wb", trap_wb, exp_trap);
      check_trap("trap_code_wb", trap_code_wb, exp_tc);
      check_rd("rd_wb", rd_wb, exp_rd);
      check_src("res_src_wb", res_src_wb, exp_src);
      check_funct3("funct3_wb", funct3_wb, exp_f3);
      check_word("alu_result_wb", alu_result_wb, exp_alu);
      check_word("pc_plus4_wb", pc_plus4_wb, exp_pc4);
      check_word("jb_target_wb", jb_target_wb, exp_tgt);
      if (exp_ld_chk)
        check_word("load_data_wb", load_data_wb, exp_ld);
    end
  endtask

  initial begin
    int errs_before;
    clk = 1'b0;
    rst_n = 1'b0;
    drive_vector('0);
    // Valid held high during reset so the reset alone clears valid_wb
    valid_mem = 1'b1;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    cycle_count = 0;
    exp_valid = 1'b0;
    $readmemh("verification/stage_mem_stim.txt", vecs);
    // Vectors end at the first word left unloaded
    num_vec = 0;
    while (num_vec < MAX_VEC && !$isunknown(vecs[num_vec]))
      num_vec++;
    cycle_limit = 4 * num_vec + 20;
    if (num_vec == 0) begin
      err_count++;
      $display("No vectors could be read from the stimulus file");
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    errs_before = err_count;
    check_bit("valid_wb", valid_wb, 1'b0);
    report_test("Reset", errs_before);
    for (int i = 0; i < num_vec; i++) begin
      errs_before = err_count;
      drive_vector(vecs[i]);
      #2;
      check_comb(vecs[i]);
      // Stalled cycles leave the expected WB state untouched
      if (!vecs[i][293])
        update_expect(vecs[i]);
      @(negedge clk);
      check_wb();
      report_test($sformatf("Vector %0d", i), errs_before);
    end
    $display("%0d tests passed, %0d tests failed, %0d mismatches",
             pass_count, fail_count, err_count);
    if (err_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* hdl/rv_stage_mem.sv */
`timescale 1ns/1ns

module rv_stage_mem (
  input logic clk,
  input logic rst_n,
  input logic mem_wb_stall,

  // From EX/MEM register
  input logic valid_mem,
  input logic reg_write_mem,
  input logic mem_read_mem,
  input logic mem_write_mem,
  input logic trap_in,
  input rv_isa_pkg::res_src_t res_src_mem,
  input rv_isa_pkg::reg_idx_t rd_mem,
  input rv_isa_pkg::funct3_t funct3_mem,
  input rv_isa_pkg::xlen_t alu_result_mem,
  input rv_isa_pkg::xlen_t rs2_data_mem,
  input rv_isa_pkg::xlen_t pc_plus4_mem,
  input rv_isa_pkg::xlen_t jb_target_mem,
  input rv_isa_pkg::trap_code_t trap_code_in,

  // Data memory, combinational read
  output logic dmem_ren,
  output logic dmem_we,
  output dmem_pkg::dmem_addr_t dmem_raddr,
  output dmem_pkg::dmem_addr_t dmem_waddr,
  output dmem_pkg::dmem_word_t dmem_wdata,
  output dmem_pkg::dmem_strb_t dmem_wstrb,
  input dmem_pkg::dmem_word_t dmem_rdata,

  // Forwarding
  output rv_isa_pkg::xlen_t result_mem,
  output rv_isa_pkg::xlen_t load_data_mem,

  // To WB
  output logic valid_wb,
  output logic reg_write_wb,
  output logic trap_wb,
  output rv_isa_pkg::res_src_t res_src_wb,
  output rv_isa_pkg::reg_idx_t rd_wb,
  output rv_isa_pkg::funct3_t funct3_wb,
  output rv_isa_pkg::xlen_t alu_result_wb,
  output rv_isa_pkg::xlen_t load_data_wb,
  output rv_isa_pkg::xlen_t pc_plus4_wb,
  output rv_isa_pkg::xlen_t jb_target_wb,
  output rv_isa_pkg::trap_code_t trap_code_wb
);

  ex_mem_if em_bus ();
  dmem_if dmem_bus ();

  logic trap_mem;
  logic misalign;
  rv_isa_pkg::trap_code_t trap_code_mem;

  // EX/MEM fields onto the shared bundle
  assign em_bus.valid = valid_mem;
  assign em_bus.reg_write = reg_write_mem;
  assign em_bus.mem_read = mem_read_mem;
  assign em_bus.mem_write = mem_write_mem;
  assign em_bus.res_src = res_src_mem;
  assign em_bus.rd = rd_mem;
  assign em_bus.funct3 = funct3_mem;
  assign em_bus.alu_result = alu_result_mem;
  assign em_bus.rs2_data = rs2_data_mem;
  assign em_bus.pc_plus4 = pc_plus4_mem;
  assign em_bus.jb_target = jb_target_mem;
  assign em_bus.trap = trap_in;
  assign em_bus.trap_code = trap_code_in;

  // Memory port, both addresses are the same word address
  assign dmem_ren = dmem_bus.ren;
  assign dmem_we = dmem_bus.we;
  assign dmem_raddr = {dmem_bus.addr[31:2], 2'b00};
  assign dmem_waddr = {dmem_bus.addr[31:2], 2'b00};
  assign dmem_wdata = dmem_bus.wdata;
  assign dmem_wstrb = dmem_bus.wstrb;
  assign dmem_bus.rdata = dmem_rdata;

  // Store format, alignment check and request gating
  mem_access access0 (
    .em(em_bus.access),
    .dmem(dmem_bus.req),
    .trap_mem(trap_mem),
    .trap_code_mem(trap_code_mem),
    .misalign(misalign)
  );

  // Load lane select and extension
  load_format ldfmt0 (
    .dmem(dmem_bus.ld),
    .funct3(funct3_mem),
    .load_data(load_data_mem)
  );

  // Forwarding mux and MEM/WB register
  mem_wb_pipe pipe0 (
    .clk(clk),
    .rst_n(rst_n),
    .mem_wb_stall(mem_wb_stall),
    .em(em_bus.pipe),
    .trap_mem(trap_mem),
    .misalign(misalign),
    .trap_code_mem(trap_code_mem),
    .load_data(load_data_mem),
    .result_mem(result_mem),
    .valid_wb(valid_wb),
    .reg_write_wb(reg_write_wb),
    .trap_wb(trap_wb),
    .res_src_wb(res_src_wb),
    .rd_wb(rd_wb),
    .funct3_wb(funct3_wb),
    .alu_result_wb(alu_result_wb),
    .load_data_wb(load_data_wb),
    .pc_plus4_wb(pc_plus4_wb),
    .jb_target_wb(jb_target_wb),
    .trap_code_wb(trap_code_wb)
  );

endmodule

/* hdl/mem_wb_pipe.sv */
`timescale 1ns/1ns

module mem_wb_pipe (
  input logic clk,
  input logic rst_n,
  input logic mem_wb_stall,
  ex_mem_if.pipe em,
  input logic trap_mem,
  input logic misalign,
  input rv_isa_pkg::trap_code_t trap_code_mem,
  input rv_isa_pkg::xlen_t load_data,
  output rv_isa_pkg::xlen_t result_mem,
  output logic valid_wb,
  output logic reg_write_wb,
  output logic trap_wb,
  output rv_isa_pkg::res_src_t res_src_wb,
  output rv_isa_pkg::reg_idx_t rd_wb,
  output rv_isa_pkg::funct3_t funct3_wb,
  output rv_isa_pkg::xlen_t alu_result_wb,
  output rv_isa_pkg::xlen_t load_data_wb,
  output rv_isa_pkg::xlen_t pc_plus4_wb,
  output rv_isa_pkg::xlen_t jb_target_wb,
  output rv_isa_pkg::trap_code_t trap_code_wb
);

  logic advance;

  // Register loads only when WB is not holding
  assign advance = ~mem_wb_stall;

  // MEM stage result for the forwarding network
  // Loads are not forwarded from here, they go through load_data_mem
  always_comb begin
    case (em.res_src)
      rv_isa_pkg::RES_PC4: result_mem = em.pc_plus4;
      rv_isa_pkg::RES_TGT: result_mem = em.jb_target;
      // RES_ALU and any unlisted code
      default: result_mem = em.alu_result;
    endcase
  end

  // Valid bit, the only control state with a reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_wb <= 1'b0;
    end else if (advance) begin
      valid_wb <= em.valid;
    end
  end

  // Payload registers
  // Contents are meaningless while valid_wb is low
  always_ff @(posedge clk) begin
    if (advance) begin
      // Trapped instructions must not write the register file
      reg_write_wb <= em.reg_write & ~trap_mem;
      res_src_wb <= em.res_src;
      rd_wb <= em.rd;
      funct3_wb <= em.funct3;
      alu_result_wb <= em.alu_result;
      load_data_wb <= load_data;
      pc_plus4_wb <= em.pc_plus4;
      jb_target_wb <= em.jb_target;
      // Incoming trap or local misalignment
      trap_wb <= em.trap | misalign;
      trap_code_wb <= trap_code_mem;
    end
  end

endmodule

/* hdl/load_format.sv */
`timescale 1ns/1ns

module load_format (
  dmem_if.ld dmem,
  input rv_isa_pkg::funct3_t funct3,
  output rv_isa_pkg::xlen_t load_data
);

  dmem_pkg::byte_off_t off;
  logic [1:0] size;
  logic is_unsigned;
  logic [7:0] lane_b;
  logic [15:0] lane_h;
  logic fill_b;
  logic fill_h;

  assign off = dmem.addr[1:0];
  assign size = funct3[1:0];
  // funct3[2] set means LBU or LHU
  assign is_unsigned = funct3[2];

  // Byte lane pick
  always_comb begin
    case (off)
      2'd0: lane_b = dmem.rdata[7:0];
      2'd1: lane_b = dmem.rdata[15:8];
      2'd2: lane_b = dmem.rdata[23:16];
      default: lane_b = dmem.rdata[31:24];
    endcase
  end

  // Halfword lane pick, bit 0 of the offset is zero for legal halfwords
  assign lane_h = off[1] ? dmem.rdata[31:16] : dmem.rdata[15:0];

  // Extension bit, zero for unsigned loads
  assign fill_b = ~is_unsigned & lane_b[7];
  assign fill_h = ~is_unsigned & lane_h[15];

  always_comb begin
    case (size)
      rv_isa_pkg::SIZE_BYTE: load_data = {{24{fill_b}}, lane_b};
      rv_isa_pkg::SIZE_HALF: load_data = {{16{fill_h}}, lane_h};
      // Word loads and the reserved size pass the word through
      default: load_data = dmem.rdata;
    endcase
  end

endmodule

/* hdl/mem_access.sv */
`timescale 1ns/1ns

module mem_access (
  ex_mem_if.access em,
  dmem_if.req dmem,
  output logic trap_mem,
  output rv_isa_pkg::trap_code_t trap_code_mem,
  output logic misalign
);

  dmem_pkg::byte_off_t off;
  logic [1:0] size;
  dmem_pkg::dmem_word_t st_data;
  dmem_pkg::dmem_strb_t st_strb;
  logic access;
  logic store_go;

  // Byte offset and size straight from the effective address and funct3
  assign off = em.alu_result[1:0];
  assign size = em.funct3[1:0];
  assign access = em.mem_read | em.mem_write;

  // Store lane placement
  // Source byte or halfword is replicated, the strobe picks the lanes
  always_comb begin
    case (size)
      rv_isa_pkg::SIZE_BYTE: begin
        st_data = {4{em.rs2_data[7:0]}};
        st_strb = 4'b0001 << off;
      end
      rv_isa_pkg::SIZE_HALF: begin
        st_data = {2{em.rs2_data[15:0]}};
        st_strb = off[1] ? 4'b1100 : 4'b0011;
      end
      rv_isa_pkg::SIZE_WORD: begin
        st_data = em.rs2_data;
        st_strb = 4'b1111;
      end
      default: begin
        // Reserved size, treated as a full word
        st_data = em.rs2_data;
        st_strb = 4'b1111;
      end
    endcase
  end

  // Alignment check for halfword and word accesses
  always_comb begin
    misalign = 1'b0;
    if (access) begin
      case (size)
        rv_isa_pkg::SIZE_HALF: misalign = off[0];
        rv_isa_pkg::SIZE_WORD: misalign = |off;
        default: misalign = 1'b0;
      endcase
    end
  end

  // Merge with the trap from earlier stages
  assign trap_mem = em.trap | misalign;
  // Misalignment found here overrides the incoming cause
  assign trap_code_mem = misalign ? rv_isa_pkg::TRAP_LDST_MISALIGN : em.trap_code;

  // No memory side effects once a trap is pending
  assign store_go = em.mem_write & ~trap_mem;
  assign dmem.ren = em.mem_read & ~trap_mem;
  assign dmem.we = store_go;
  assign dmem.addr = em.alu_result;
  assign dmem.wdata = st_data;
  // Strobes stay low unless the store really goes out
  assign dmem.wstrb = store_go ? st_strb : 4'b0000;

endmodule

/* hdl/dmem_if.sv */
`timescale 1ns/1ns

// Data memory request and read data
interface dmem_if;

  logic ren;
  logic we;
  // Full byte address of the access
  // The low two bits are cleared where the request leaves the stage
  dmem_pkg::dmem_addr_t addr;
  dmem_pkg::dmem_word_t wdata;
  dmem_pkg::dmem_strb_t wstrb;
  // Combinational read data, same cycle as ren
  dmem_pkg::dmem_word_t rdata;

  // Request generator
  modport req (
    output ren, we, addr, wdata, wstrb
  );

  // Load formatter needs the word and the byte offset
  modport ld (
    input rdata, addr
  );

  // Memory side of the stage boundary
  modport port (
    input ren, we, addr, wdata, wstrb,
    output rdata
  );

endinterface

/* hdl/ex_mem_if.sv */
`timescale 1ns/1ns

// Instruction fields latched by the EX/MEM register
interface ex_mem_if;

  // Control
  logic valid;
  logic reg_write;
  logic mem_read;
  logic mem_write;
  rv_isa_pkg::res_src_t res_src;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::funct3_t funct3;

  // Datapath
  rv_isa_pkg::xlen_t alu_result;
  rv_isa_pkg::xlen_t rs2_data;
  rv_isa_pkg::xlen_t pc_plus4;
  rv_isa_pkg::xlen_t jb_target;

  // Trap raised by an earlier stage
  logic trap;
  rv_isa_pkg::trap_code_t trap_code;

  // Memory access side only needs the address, store data and trap state
  modport access (
    input mem_read, mem_write, funct3, alu_result, rs2_data, trap, trap_code
  );

  // Pipeline register side sees every field
  modport pipe (
    input valid, reg_write, mem_read, mem_write, res_src, rd, funct3,
    input alu_result, rs2_data, pc_plus4, jb_target, trap, trap_code
  );

endinterface

/* hdl/dmem_pkg.sv */
package dmem_pkg;

  // One data word on the memory bus
  typedef logic [31:0] dmem_word_t;

  // Byte address, word aligned when it leaves the stage
  typedef logic [31:0] dmem_addr_t;

  // One strobe bit per byte lane, bit 0 is the lowest byte
  typedef logic [3:0] dmem_strb_t;

  // Byte position inside a 32-bit word
  typedef logic [1:0] byte_off_t;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Datapath word, RV32 only
  typedef logic [31:0] xlen_t;

  // Load/store funct3
  // Bits [1:0] give the access size, bit 2 marks an unsigned load
  typedef logic [2:0] funct3_t;

  // Access size codes from funct3[1:0]
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

  // Result source for forwarding and writeback
  // Codes not listed here fall back to the ALU result
  typedef enum logic [2:0] {
    RES_ALU = 3'b000,
    RES_PC4 = 3'b010,
    RES_TGT = 3'b011
  } res_src_t;

  // Trap cause carried down the pipe
  typedef logic [1:0] trap_code_t;

  // Load or store address misaligned for its size
  localparam trap_code_t TRAP_LDST_MISALIGN = 2'd2;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

endpackage
